//--- Makefile
SRCS := $(shell cat sim.f)

.PHONY: run clean

obj_dir/Vobj_engine_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module obj_engine_tb -f sim.f

run: obj_dir/Vobj_engine_tb
	@out="$$(./obj_dir/Vobj_engine_tb)"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

//--- common/obj_pkg.sv
// Shared constants and packed records of the sprite layer, imported by each block that needs them
`default_nettype none

package obj_pkg;

    localparam int         OBJ_ENTRIES        = 128;    // Table entries, 4 words each
    localparam int         OBJ_AW             = 9;      // Table word address width
    localparam logic [7:0] OBJ_END_MARK       = 8'hff;  // Bottom line value that ends the table
    localparam logic [8:0] OBJ_HSTART         = 9'd0;   // Readout position while hsn is low
    localparam int         OBJ_WORDS_PER_LINE = 4;      // 16 pixels at 4 bits each
    localparam logic [8:0] OBJ_XMAX           = 9'd320; // First column off the visible area

    // CPU access to the attribute table
    typedef struct packed {
        logic        cs;
        logic [8:0]  addr;   // Word address
        logic [15:0] data;   // Write data
        logic [1:0]  dswn;   // Byte write enables, active low
    } obj_cpu_req_t;

    // One table entry, word 3 in the top bits down to word 0 in the low bits
    typedef struct packed {
        // Word 3
        logic [1:0]  prio;
        logic [5:0]  pal;
        logic [2:0]  rsv3;   // Unused bits
        logic        hflip;
        logic [3:0]  bank;
        // Word 2
        logic [15:0] offset; // Graphics word offset inside the bank
        // Word 1
        logic        hide;
        logic [5:0]  rsv1;   // Unused bits
        logic [8:0]  xpos;
        // Word 0
        logic [7:0]  bottom; // First line below the sprite
        logic [7:0]  top;
    } obj_entry_t;

    // Scanner to drawer command
    typedef struct packed {
        logic [8:0]  xpos;
        logic [19:0] addr;   // First graphics word of this line
        logic        hflip;
        logic [1:0]  prio;
        logic [5:0]  pal;
    } obj_cmd_t;

    // Line buffer pixel, color 0 is transparent and the erased value
    typedef struct packed {
        logic [1:0]  prio;
        logic [5:0]  pal;
        logic [3:0]  color;
    } obj_pxl_t;

endpackage

`default_nettype wire

//--- obj_draw/obj_draw.sv
// Sprite drawer, fetches one line of graphics from the ROM and writes pixels to the line buffer
`default_nettype none
`timescale 1ns/1ps

module obj_draw import obj_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start,
    output logic                   busy,
    input  wire obj_cmd_t          cmd,
    input  wire logic              obj_ok,
    output logic                   obj_cs,
    output logic [19:0]            obj_addr,
    input  wire logic [15:0]       obj_data,
    output logic                   bf_we,
    output logic [OBJ_AW-1:0]      bf_addr,
    output obj_pxl_t               bf_data
);

    typedef enum logic [1:0] {
        DR_IDLE,
        DR_REQ,     // ROM request pending
        DR_SHIFT    // Four nibbles out
    } draw_state_t;

    draw_state_t state;
    obj_cmd_t    cur;       // Latched command
    logic [1:0]  word;      // Graphics word in the line
    logic [3:0]  pix;       // Running pixel count
    logic [15:0] data;      // Shift register
    logic [3:0]  nibble;
    logic        last_nib;

    assign nibble   = cur.hflip ? data[3:0] : data[15:12]; // Flip reads from the low end
    assign last_nib = pix[1:0] == 2'd3;

    assign bf_addr       = cur.xpos + 9'(pix);
    assign bf_data.prio  = cur.prio;
    assign bf_data.pal   = cur.pal;
    assign bf_data.color = nibble;
    // Skip transparent and off-screen pixels
    assign bf_we = (state == DR_SHIFT) && (nibble != 4'd0) && (bf_addr < OBJ_XMAX);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= DR_IDLE;
            busy   <= 1'b0;
            obj_cs <= 1'b0;
            word   <= 2'd0;
            pix    <= 4'd0;
        end else begin
            case (state)
                DR_IDLE: if (start) begin
                    state  <= DR_REQ;
                    busy   <= 1'b1;
                    obj_cs <= 1'b1; // First fetch right away
                    word   <= 2'd0;
                    pix    <= 4'd0;
                end
                DR_REQ: if (obj_ok) begin
                    obj_cs <= 1'b0; // Low for the whole shift
                    state  <= DR_SHIFT;
                end
                DR_SHIFT: begin
                    pix <= pix + 4'd1;
                    if (last_nib) begin
                        if (word == 2'(OBJ_WORDS_PER_LINE - 1)) begin
                            state <= DR_IDLE;
                            busy  <= 1'b0; // Last write is this cycle
                        end else begin
                            word   <= word + 2'd1;
                            state  <= DR_REQ;
                            obj_cs <= 1'b1;
                        end
                    end
                end
                default: state <= DR_IDLE;
            endcase
        end
    end

    // Command, ROM address and pixel data
    always_ff @(posedge clk) begin
        if (state == DR_IDLE && start) begin
            cur      <= cmd;
            obj_addr <= cmd.addr;
        end
        if (state == DR_REQ && obj_ok) begin
            data <= obj_data;
        end
        if (state == DR_SHIFT) begin
            data <= cur.hflip ? (data >> 4) : (data << 4);
            if (last_nib) obj_addr <= obj_addr + 20'd1; // Next word of the row
        end
    end

endmodule

`default_nettype wire

//--- obj_ram/obj_ram.sv
// Sprite attribute table RAM, CPU port with byte writes and a read-only port for the scanner
`default_nettype none
`timescale 1ns/1ps

module obj_ram import obj_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire obj_cpu_req_t      cpu_req,
    output logic [15:0]            cpu_din,
    input  wire logic [OBJ_AW-1:0] tbl_addr,
    output logic [15:0]            tbl_dout
);

    localparam int DEPTH = OBJ_ENTRIES * 4;

    logic [15:0] mem [DEPTH];
    logic        cpu_rd;

    assign cpu_rd = cpu_req.cs && (&cpu_req.dswn); // Both enables high is a read

    // CPU writes, one byte lane per enable
    always_ff @(posedge clk) begin
        if (cpu_req.cs && !cpu_req.dswn[0]) begin
            mem[cpu_req.addr][7:0] <= cpu_req.data[7:0];
        end
        if (cpu_req.cs && !cpu_req.dswn[1]) begin
            mem[cpu_req.addr][15:8] <= cpu_req.data[15:8];
        end
    end

    // CPU readback, held until the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            cpu_din <= 16'd0;
        end else if (cpu_rd) begin
            cpu_din <= mem[cpu_req.addr];
        end
    end

    // Scanner port
    // One clock of latency, the scanner counts on it
    always_ff @(posedge clk) begin
        if (rst) begin
            tbl_dout <= 16'd0;
        end else begin
            tbl_dout <= mem[tbl_addr];
        end
    end

endmodule

`default_nettype wire

//--- obj_scan/obj_scan.sv
// Table walker, decodes entries on each line and hands visible sprites to the drawer
`default_nettype none
`timescale 1ns/1ps

module obj_scan import obj_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              hstart,
    input  wire logic [8:0]        vrender,
    output logic [OBJ_AW-1:0]      tbl_addr,
    input  wire logic [15:0]       tbl_dout,
    output logic                   dr_start,
    input  wire logic              dr_busy,
    output obj_cmd_t               dr_cmd
);

    typedef enum logic [1:0] {
        SC_IDLE,    // Done for this line
        SC_READ,    // Fetch the four words of an entry
        SC_CHECK,   // Line range and hide test
        SC_WAIT     // Hold until the drawer is free
    } scan_state_t;

    scan_state_t state;
    logic [6:0]  entry;     // Entry index
    logic [2:0]  cnt;       // Word being addressed, data lags by one
    logic [8:0]  vline;     // Line being prepared
    obj_entry_t  ent;
    logic [7:0]  row;
    logic        visible;
    logic        last_entry;
    logic        adv;       // Move on to the next entry
    obj_cmd_t    next_cmd;

    assign tbl_addr   = {entry, cnt[1:0]};
    assign row        = vline[7:0] - ent.top; // Row inside the sprite
    assign visible    = !ent.hide && (vline >= {1'b0, ent.top}) && (vline < {1'b0, ent.bottom});
    assign last_entry = entry == 7'(OBJ_ENTRIES - 1);
    assign adv        = ((state == SC_CHECK) && !visible) || ((state == SC_WAIT) && !dr_busy);

    always_comb begin
        next_cmd.xpos  = ent.xpos;
        // Bank picks the 64k word page, each row is 4 words
        next_cmd.addr  = {ent.bank, 16'd0} + 20'(ent.offset)
                       + 20'(row) * 20'(OBJ_WORDS_PER_LINE);
        next_cmd.hflip = ent.hflip;
        next_cmd.prio  = ent.prio;
        next_cmd.pal   = ent.pal;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SC_IDLE;
            entry    <= 7'd0;
            cnt      <= 3'd0;
            vline    <= 9'd0;
            dr_start <= 1'b0;
        end else begin
            dr_start <= 1'b0; // Single cycle pulse
            if (hstart) begin
                state <= SC_READ; // Restart from entry 0
                entry <= 7'd0;
                cnt   <= 3'd0;
                vline <= vrender + 9'd1;
            end else begin
                case (state)
                    SC_READ: begin
                        cnt <= cnt + 3'd1;
                        if (cnt == 3'd1 && tbl_dout[15:8] == OBJ_END_MARK) begin
                            state <= SC_IDLE; // Terminator in word 0
                        end else if (cnt == 3'd4) begin
                            state <= SC_CHECK;
                        end
                    end
                    SC_CHECK: if (visible) state <= SC_WAIT;
                    SC_WAIT:  if (!dr_busy) dr_start <= 1'b1;
                    default: ;
                endcase
                if (adv) begin
                    if (last_entry) begin
                        state <= SC_IDLE; // Whole table walked
                    end else begin
                        entry <= entry + 7'd1;
                        cnt   <= 3'd0;
                        state <= SC_READ;
                    end
                end
            end
        end
    end

    // Entry words as they come back from the RAM
    always_ff @(posedge clk) begin
        if (state == SC_READ) begin
            case (cnt)
                3'd1: ent[15:0]  <= tbl_dout;
                3'd2: ent[31:16] <= tbl_dout;
                3'd3: ent[47:32] <= tbl_dout;
                3'd4: ent[63:48] <= tbl_dout;
                default: ;
            endcase
        end
    end

    // Command stays put while the drawer runs
    always_ff @(posedge clk) begin
        if (state == SC_WAIT && !dr_busy) begin
            dr_cmd <= next_cmd;
        end
    end

endmodule

`default_nettype wire

//--- sim.f
common/obj_pkg.sv
obj_ram/obj_ram.sv
obj_scan/obj_scan.sv
obj_draw/obj_draw.sv
verilog/obj_line_buffer.sv
verilog/obj_engine.sv
verif/obj_engine_checker.sv
verif/obj_engine_tb.sv

//--- verif/obj_engine_checker.sv
// Drawer protocol assertions, bound into obj_draw from the testbench
`default_nettype none
`timescale 1ns/1ps

module obj_engine_checker (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        start,
    input  wire logic        busy,
    input  wire logic        obj_cs,
    input  wire logic        obj_ok,
    input  wire logic [19:0] obj_addr,
    input  wire logic        bf_we
);

    int fail_count = 0;   // Assertion failures so far

    // ROM request held steady until acknowledged
    req_hold: assert property (@(posedge clk) disable iff (rst)
        obj_cs && !obj_ok |=> obj_cs && $stable(obj_addr))
        else begin
            $error("ROM request dropped or address moved before obj_ok");
            fail_count++;
        end

    // Gap of at least one cycle between requests
    req_gap: assert property (@(posedge clk) disable iff (rst) obj_ok |=> !obj_cs)
        else begin
            $error("obj_cs still high after obj_ok");
            fail_count++;
        end

    start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else begin
            $error("Draw command started while drawer busy");
            fail_count++;
        end

    // Pixel writes stay inside the busy window
    write_busy: assert property (@(posedge clk) disable iff (rst) bf_we |-> busy)
        else begin
            $error("Line buffer written while drawer not busy");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- verif/obj_engine_tb.sv
// Sprite layer testbench, runs video timing and a ROM model, replays verif/obj_stimulus.txt
`default_nettype none
`timescale 1ns/1ps

module obj_engine_tb import obj_pkg::*; ();

    logic         clk;
    logic         rst      = 1'b1;
    logic         pxl_cen  = 1'b0;
    logic         hstart   = 1'b0;
    logic         hsn      = 1'b0;
    logic [8:0]   vrender  = 9'd0;
    obj_cpu_req_t cpu_req  = '0;
    logic         obj_ok   = 1'b0;
    logic [15:0]  obj_data = 16'd0;
    logic [15:0]  cpu_din;
    logic         obj_cs;
    logic [19:0]  obj_addr;
    obj_pxl_t     pxl;

    logic [9:0]   hcyc = 10'd1;   // Clock inside the 800-clock line
    logic [9:0]   hnext;
    logic         rd_q = 1'b0;    // Pixel read last cycle
    logic [8:0]   pos_q = 9'd0;
    logic [8:0]   line_q = 9'd0;
    obj_pxl_t     cap [16][320];  // Captured pixels per line
    logic [511:0] done_line = '0;
    integer       seed = 32'hcd41;
    int           rom_delay;
    int           rom_cnt = 0;
    logic         rom_busy = 1'b0;
    int           rec_lines = 0;  // Stimulus file length, sizes the watchdog
    int           cpu_errors = 0;
    int           pxl_errors = 0;
    int           other_errors = 0;

    obj_engine obj_engine_i (.*);

    bind obj_draw obj_engine_checker draw_chk_i (
        .clk(clk), .rst(rst), .start(start), .busy(busy), .obj_cs(obj_cs),
        .obj_ok(obj_ok), .obj_addr(obj_addr), .bf_we(bf_we)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // 400 pixels per line, 80 of them with hsn low, pixel enable every other clock
    assign hnext = (hcyc == 10'd799) ? 10'd0 : hcyc + 10'd1;
    always @(posedge clk) begin
        if (rst) begin
            hcyc    <= 10'd1; // No hstart on the first line, table gets written first
            hstart  <= 1'b0;
            hsn     <= 1'b0;
            pxl_cen <= 1'b0;
            vrender <= 9'd0;
        end else begin
            hcyc    <= hnext;
            hstart  <= hnext == 10'd0;
            hsn     <= hnext >= 10'd160;
            pxl_cen <= hnext[0];
            if (hnext == 10'd0) vrender <= vrender + 9'd1;
        end
    end

    // Note which position was read, pxl shows it one clock later
    always @(posedge clk) begin
        rd_q   <= !rst && pxl_cen && hsn;
        pos_q  <= 9'((hcyc - 10'd161) >> 1);
        line_q <= vrender;
    end

    always @(negedge clk) begin
        if (rd_q) begin
            cap[line_q[3:0]][pos_q] <= pxl;
            if (pos_q == 9'd319) done_line[line_q] <= 1'b1; // Whole line seen
        end
    end

    // Graphics ROM, data is address XOR a constant after 0 to 3 clocks
    always @(posedge clk) begin
        if (rst) begin
            obj_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (obj_ok) begin
            obj_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (obj_cs && !rom_busy) begin
            rom_delay = $random(seed) & 3;
            rom_busy <= 1'b1;
            rom_cnt  <= rom_delay;
            if (rom_delay == 0) begin
                obj_ok   <= 1'b1;
                obj_data <= obj_addr[15:0] ^ 16'h5a3c;
            end
        end else if (rom_busy && rom_cnt > 0) begin
            rom_cnt <= rom_cnt - 1;
            if (rom_cnt == 1) begin
                obj_ok   <= 1'b1;
                obj_data <= obj_addr[15:0] ^ 16'h5a3c;
            end
        end
    end

    task automatic check_cpu(input logic [8:0] addr, input logic [15:0] got, exp);
        if (got !== exp) begin
            cpu_errors++;
            $display("CHECK FAILED cpu_din addr %h got %h expected %h", addr, got, exp);
        end
    endtask

    task automatic check_pxl(input logic [8:0] line, x, input obj_pxl_t got, exp);
        if (got !== exp) begin
            pxl_errors++;
            $display("CHECK FAILED pxl line %h x %h got %h expected %h", line, x, got, exp);
        end
    endtask

    task automatic cpu_access(input logic [8:0] addr, input logic [15:0] data,
                              input logic [1:0] dswn);
        @(posedge clk);
        cpu_req <= '{cs: 1'b1, addr: addr, data: data, dswn: dswn};
        @(posedge clk);
        cpu_req <= '0;
    endtask

    task automatic wait_line(input logic [8:0] line);
        while (!done_line[line]) @(posedge clk);
    endtask

    // Watchdog, one line time per stimulus record plus slack
    initial begin
        wait (rec_lines > 0);
        repeat (rec_lines * 800 + 4000) @(posedge clk);
        $display("Timeout, stimulus did not complete in the allowed time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int          fd;
        int          n;
        int          nrec;
        int          chk_errors;
        string       line_txt;
        byte         kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [8:0]  cur_line;
        cur_line = 9'd0;
        nrec     = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("verif/obj_stimulus.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the stimulus file");
        end else begin
            while ($fgets(line_txt, fd)) nrec++; // Count first for the watchdog
            rec_lines = nrec;
            $fclose(fd);
            fd = $fopen("verif/obj_stimulus.txt", "r");
            while ($fgets(line_txt, fd)) begin
                n = $sscanf(line_txt, "%c %h %h %h", kind, a, b, c);
                case (kind)
                    // Missing dswn column is a full word write
                    "W": cpu_access(a[8:0], b[15:0], (n > 3) ? c[1:0] : 2'b00);
                    "R": begin
                        cpu_access(a[8:0], 16'd0, 2'b11);
                        @(posedge clk); // Readback registered one clock after cs
                        check_cpu(a[8:0], cpu_din, b[15:0]);
                    end
                    "L": begin
                        cur_line = a[8:0];
                        wait_line(cur_line);
                    end
                    "P": check_pxl(cur_line, a[8:0], cap[cur_line[3:0]][a[8:0]], b[11:0]);
                    "#", "\n", " ": ;
                    default: begin
                        other_errors++;
                        $display("Unknown stimulus record kind in line: %s", line_txt);
                    end
                endcase
            end
            $fclose(fd);
        end
        chk_errors = obj_engine_i.u_draw.draw_chk_i.fail_count;
        $display("Errors: cpu %0d pixel %0d assertion %0d other %0d",
                 cpu_errors, pxl_errors, chk_errors, other_errors);
        if (cpu_errors + pxl_errors + chk_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/obj_stimulus.txt
# W addr data dswn | R addr expected | L line (wait until shown)
# P x expected pixel {prio,pal,color} on the last L line, all values hex
W 100 1234 0
W 100 abcd 2
R 100 12cd
W 100 ef56 1
W 100 9999 3
R 100 efcd
W 000 0604
W 001 0020
W 002 0a3c
W 003 4500
R 003 4500
W 004 0504
W 005 0064
W 006 0a3c
W 007 8310
W 008 0605
W 009 0024
W 00a 0a3c
W 00b c100
W 00c 0706
W 00d 8040
W 010 0c0a
W 011 0050
W 014 ff00
W 018 0800
W 019 0060
L 004
P 01f 000
P 020 455
P 021 000
P 024 455
P 027 451
P 02f 453
P 030 000
P 064 000
P 067 835
P 068 831
P 073 835
L 005
P 022 457
P 024 c15
P 025 000
P 026 457
P 02b c11
P 02f c12
P 030 c15
L 006
P 020 000
P 024 000
P 040 000
P 060 000
P 067 000
L 007
P 026 000
P 030 000
P 060 000

//--- verilog/obj_engine.sv
// Sprite layer top, ties the table, scanner, drawer and line buffer to the video timing
`default_nettype none
`timescale 1ns/1ps

module obj_engine import obj_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         pxl_cen,  // Pixel clock enable
    input  wire logic         hstart,
    input  wire logic         hsn,
    input  wire logic [8:0]   vrender,
    // CPU side
    input  wire obj_cpu_req_t cpu_req,
    output logic [15:0]       cpu_din,
    // Graphics ROM
    input  wire logic         obj_ok,
    output logic              obj_cs,
    output logic [19:0]       obj_addr,
    input  wire logic [15:0]  obj_data,
    // Video
    output obj_pxl_t          pxl
);

    logic [OBJ_AW-1:0] tbl_addr;
    logic [15:0]       tbl_dout;
    logic              dr_start;
    logic              dr_busy;
    obj_cmd_t          dr_cmd;
    logic              bf_we;
    logic [OBJ_AW-1:0] bf_addr;
    obj_pxl_t          bf_data;
    logic [8:0]        hpos;    // Readout position

    obj_ram u_ram (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .cpu_din  (cpu_din),
        .tbl_addr (tbl_addr),
        .tbl_dout (tbl_dout)
    );

    obj_scan u_scan (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .vrender  (vrender),
        .tbl_addr (tbl_addr),
        .tbl_dout (tbl_dout),
        .dr_start (dr_start),
        .dr_busy  (dr_busy),
        .dr_cmd   (dr_cmd)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .start    (dr_start),
        .busy     (dr_busy),
        .cmd      (dr_cmd),
        .obj_ok   (obj_ok),
        .obj_cs   (obj_cs),
        .obj_addr (obj_addr),
        .obj_data (obj_data),
        .bf_we    (bf_we),
        .bf_addr  (bf_addr),
        .bf_data  (bf_data)
    );

    always_ff @(posedge clk) begin
        if (rst || !hsn) begin
            hpos <= OBJ_HSTART;       // Parked through blanking
        end else if (pxl_cen) begin
            hpos <= hpos + 9'd1;
        end
    end

    // Reads only while hsn is high so column 0 is not erased during blanking
    obj_line_buffer u_line (
        .clk     (clk),
        .rst     (rst),
        .hstart  (hstart),
        .wr_addr (bf_addr),
        .wr_data (bf_data),
        .we      (bf_we),
        .rd_addr (hpos),
        .rd      (pxl_cen && hsn),
        .rd_data (pxl)
    );

endmodule

`default_nettype wire

//--- verilog/obj_line_buffer.sv
// Ping-pong sprite line buffer, drawn on one half while the other is read out and erased
`default_nettype none
`timescale 1ns/1ps

module obj_line_buffer import obj_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              hstart,
    input  wire logic [OBJ_AW-1:0] wr_addr,
    input  wire obj_pxl_t          wr_data,
    input  wire logic              we,
    input  wire logic [OBJ_AW-1:0] rd_addr,
    input  wire logic              rd,
    output obj_pxl_t               rd_data
);

    logic     half;     // Half taking drawer writes
    logic     rd_sel;   // Half that produced rd_data
    obj_pxl_t q [2];

    always_ff @(posedge clk) begin
        if (rst) begin
            half   <= 1'b0;
            rd_sel <= 1'b0;
        end else begin
            if (hstart) half <= ~half;  // Swap on each new line
            if (rd) rd_sel <= ~half;
        end
    end

    // One write port per half, either draw or erase
    for (genvar h = 0; h < 2; h++) begin : g_half
        obj_pxl_t mem [2**OBJ_AW];

        always_ff @(posedge clk) begin
            if (half == 1'(h)) begin
                if (we) mem[wr_addr] <= wr_data;
            end else if (rd) begin
                q[h]         <= mem[rd_addr];
                mem[rd_addr] <= '0; // Clean for the next draw
            end
        end
    end

    assign rd_data = q[rd_sel];

endmodule

`default_nettype wire
